// ==== source/cipher_macros.svh ====
`ifndef CIPHER_MACROS_SVH
`define CIPHER_MACROS_SVH

// Cipher and queue sizing
`define CIPHER_ROUNDS 8
`define QUEUE_DEPTH   4

// APB address width
`define APB_ADDR_W    8

// Register map
`define REG_KEY       8'h00
`define REG_PT        8'h04
`define REG_CTRL      8'h08
`define REG_STATUS    8'h0C
`define REG_RESULT    8'h10
`define REG_TAG       8'h14

`endif

// ==== source/cipher_pkg.sv ====
`default_nettype none

package cipher_pkg;

  // Data block and key
  typedef logic [31:0] block_t;
  typedef logic [31:0] key_t;

  // Job sequence number, wraps around
  typedef logic [3:0] tag_t;

  // Source queue payload
  typedef struct packed {
    block_t pt;
    tag_t   tag;
  } job_t;

  // Sink queue payload
  typedef struct packed {
    block_t ct;
    tag_t   tag;
  } result_t;

  typedef enum logic [1:0] {
    IDLE,
    STARTING,
    WORKING,
    FINISHED
  } cipher_state_t;

endpackage

`default_nettype wire

// ==== source/stream_queue_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_macros.svh"

interface stream_queue_if #(
  parameter type T     = logic,
  parameter int  DEPTH = `QUEUE_DEPTH
);

  logic                         push;
  T                             wdata;
  logic                         full;
  logic                         pop;
  T                             rdata;
  logic                         empty;
  logic [$clog2(DEPTH+1)-1:0]   level;

  modport queue   (input push, wdata, pop, output full, rdata, empty, level);
  // Control and data split so a transfer can be steered by one block
  modport wr_ctl  (output push, input full, level);
  modport wr_data (output wdata);
  modport rd_ctl  (output pop, input empty, level);
  modport rd_data (input rdata);

endinterface

`default_nettype wire

// ==== source/stream_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_macros.svh"

module stream_queue #(
  parameter type T     = logic,
  parameter int  DEPTH = `QUEUE_DEPTH
) (
  input  logic           clk,
  input  logic           reset_n,
  input  logic           clear_i,
  stream_queue_if.queue  q
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [LW-1:0] count;
  logic          do_push;
  logic          do_pop;

  // Pointer wrap for any depth
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_push = q.push & ~q.full;
  assign do_pop  = q.pop & ~q.empty;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      // Simultaneous push and pop keeps the level
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= q.wdata;
  end

  // Head entry visible before the pop
  assign q.rdata = mem[rd_ptr];
  assign q.full  = (count == LW'(DEPTH));
  assign q.empty = (count == '0);
  assign q.level = count;

endmodule

`default_nettype wire

// ==== source/cipher_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_macros.svh"

module cipher_regfile
  import cipher_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  logic                   busy_i,
  input  logic                   done_i,
  output logic                   start_o,
  output logic                   clear_o,
  output key_t                   key_o,
  stream_queue_if.wr_ctl         src_ctl,
  stream_queue_if.wr_data        src_data,
  stream_queue_if.rd_ctl         snk_ctl,
  stream_queue_if.rd_data        snk_data
);

  logic        access;
  logic        wr_en;
  logic        rd_en;
  logic        hit_key;
  logic        hit_pt;
  logic        hit_ctrl;
  logic        hit_status;
  logic        hit_result;
  logic        hit_tag;
  logic        mapped;
  key_t        key_q;
  tag_t        tag_q;
  job_t        push_job;
  result_t     head;
  logic [31:0] status;

  // Zero wait states, the access phase completes the transfer
  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i;
  assign rd_en    = access & ~pwrite_i;
  assign pready_o = 1'b1;

  assign hit_key    = (paddr_i == `REG_KEY);
  assign hit_pt     = (paddr_i == `REG_PT);
  assign hit_ctrl   = (paddr_i == `REG_CTRL);
  assign hit_status = (paddr_i == `REG_STATUS);
  assign hit_result = (paddr_i == `REG_RESULT);
  assign hit_tag    = (paddr_i == `REG_TAG);
  assign mapped     = hit_key | hit_pt | hit_ctrl | hit_status | hit_result | hit_tag;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_q <= '0;
      tag_q <= '0;
    end else begin
      if (wr_en && hit_key) key_q <= pwdata_i;
      // Next sequence number per accepted plaintext
      if (src_ctl.push) tag_q <= tag_q + 1'b1;
    end
  end

  assign key_o = key_q;

  // Plaintext push, dropped when the source queue is full
  assign push_job.pt   = pwdata_i;
  assign push_job.tag  = tag_q;
  assign src_data.wdata = push_job;
  assign src_ctl.push  = wr_en & hit_pt & ~src_ctl.full;

  assign start_o = wr_en & hit_ctrl & pwdata_i[0];
  assign clear_o = wr_en & hit_ctrl & pwdata_i[1];

  // Result read pops the sink head
  assign head        = snk_data.rdata;
  assign snk_ctl.pop = rd_en & hit_result & ~snk_ctl.empty;

  always_comb begin
    status       = '0;
    status[0]    = done_i;
    status[1]    = busy_i;
    status[6:4]  = src_ctl.level;
    status[10:8] = snk_ctl.level;
  end

  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      if (hit_key) begin
        prdata_o = key_q;
      end else if (hit_status) begin
        prdata_o = status;
      end else if (hit_result && !snk_ctl.empty) begin
        prdata_o = head.ct;
      end else if (hit_tag && !snk_ctl.empty) begin
        prdata_o = {28'b0, head.tag};
      end
    end
  end

  // Error response in the access cycle
  assign pslverr_o = access & (~mapped
                               | (pwrite_i & hit_pt & src_ctl.full)
                               | (~pwrite_i & hit_result & snk_ctl.empty));

endmodule

`default_nettype wire

// ==== source/cipher_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module cipher_fsm
  import cipher_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,
  input  logic           clear_i,
  input  logic           start_i,
  input  logic           last_i,
  output logic           count_en_o,
  output logic           load_o,
  output logic           round_en_o,
  output logic           done_o,
  output logic           busy_o,
  stream_queue_if.rd_ctl src,
  stream_queue_if.wr_ctl snk
);

  cipher_state_t state_q;
  cipher_state_t state_d;
  logic          done_q;
  logic          streams_ready;

  // Both streams able to take one block
  assign streams_ready = ~src.empty & ~snk.full;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Sticky done, set on the way from FINISHED back to IDLE
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      done_q <= 1'b0;
    end else if (clear_i || start_i) begin
      done_q <= 1'b0;
    end else if (state_q == FINISHED && src.empty) begin
      done_q <= 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) state_d = STARTING;
      end
      STARTING: begin
        if (streams_ready) state_d = WORKING;
      end
      WORKING: begin
        if (last_i) state_d = FINISHED;
      end
      FINISHED: begin
        state_d = src.empty ? IDLE : STARTING;
      end
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    load_o     = (state_q == STARTING) & streams_ready;
    src.pop    = load_o;
    count_en_o = (state_q == WORKING);
    round_en_o = (state_q == WORKING);
    snk.push   = (state_q == FINISHED);
    busy_o     = (state_q != IDLE);
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// ==== source/round_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_macros.svh"

module round_counter (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       count_en_i,
  output logic [2:0] round_o,
  output logic       last_o
);

  logic [2:0] round_q;

  // Restarts from zero whenever WORKING is left
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      round_q <= '0;
    end else if (count_en_i) begin
      round_q <= round_q + 1'b1;
    end else begin
      round_q <= '0;
    end
  end

  assign round_o = round_q;
  assign last_o  = count_en_i & (round_q == 3'(`CIPHER_ROUNDS - 1));

endmodule

`default_nettype wire

// ==== source/cipher_round_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module cipher_round_engine
  import cipher_pkg::*;
(
  input  logic            clk,
  input  logic            reset_n,
  input  logic            load_i,
  input  logic            round_en_i,
  input  logic [2:0]      round_i,
  input  key_t            key_i,
  stream_queue_if.rd_data src,
  stream_queue_if.wr_data snk
);

  block_t  state_q;
  tag_t    tag_q;
  job_t    job;
  result_t res;

  function automatic block_t rotl(input block_t x, input int unsigned n);
    return (x << n) | (x >> (32 - n));
  endfunction

  // One round: key mix, rotate, add round number
  function automatic block_t cipher_round(input block_t s, input key_t k, input logic [2:0] r);
    block_t t;
    t = s ^ rotl(k, r);
    t = rotl(t, 3);
    return t + {29'b0, r};
  endfunction

  assign job = src.rdata;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= '0;
      tag_q   <= '0;
    end else if (load_i) begin
      state_q <= job.pt;
      tag_q   <= job.tag;
    end else if (round_en_i) begin
      state_q <= cipher_round(state_q, key_i, round_i);
    end
  end

  assign res.ct    = state_q;
  assign res.tag   = tag_q;
  assign snk.wdata = res;

endmodule

`default_nettype wire

// ==== source/cipher_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_macros.svh"

module cipher_top
  import cipher_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  output logic                   irq_o
);

  logic       busy;
  logic       start;
  logic       clear;
  key_t       key;
  logic       count_en;
  logic       load;
  logic       round_en;
  logic [2:0] round;
  logic       last;

  stream_queue_if #(.T(job_t),    .DEPTH(`QUEUE_DEPTH)) src_if ();
  stream_queue_if #(.T(result_t), .DEPTH(`QUEUE_DEPTH)) snk_if ();

  // Plaintext jobs
  stream_queue #(.T(job_t), .DEPTH(`QUEUE_DEPTH)) u_src_queue (
    .clk     (clk),
    .reset_n (reset_n),
    .clear_i (clear),
    .q       (src_if.queue)
  );

  // Ciphertext results
  stream_queue #(.T(result_t), .DEPTH(`QUEUE_DEPTH)) u_snk_queue (
    .clk     (clk),
    .reset_n (reset_n),
    .clear_i (clear),
    .q       (snk_if.queue)
  );

  // irq_o is the done flag itself
  cipher_regfile u_regfile (
    .clk       (clk),
    .reset_n   (reset_n),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .busy_i    (busy),
    .done_i    (irq_o),
    .start_o   (start),
    .clear_o   (clear),
    .key_o     (key),
    .src_ctl   (src_if.wr_ctl),
    .src_data  (src_if.wr_data),
    .snk_ctl   (snk_if.rd_ctl),
    .snk_data  (snk_if.rd_data)
  );

  cipher_fsm u_fsm (
    .clk        (clk),
    .reset_n    (reset_n),
    .clear_i    (clear),
    .start_i    (start),
    .last_i     (last),
    .count_en_o (count_en),
    .load_o     (load),
    .round_en_o (round_en),
    .done_o     (irq_o),
    .busy_o     (busy),
    .src        (src_if.rd_ctl),
    .snk        (snk_if.wr_ctl)
  );

  round_counter u_round_counter (
    .clk        (clk),
    .reset_n    (reset_n),
    .count_en_i (count_en),
    .round_o    (round),
    .last_o     (last)
  );

  cipher_round_engine u_engine (
    .clk        (clk),
    .reset_n    (reset_n),
    .load_i     (load),
    .round_en_i (round_en),
    .round_i    (round),
    .key_i      (key),
    .src        (src_if.rd_data),
    .snk        (snk_if.wr_data)
  );

endmodule

`default_nettype wire

// ==== dv/cipher_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_macros.svh"

module cipher_asserts
  import cipher_pkg::*;
#(
  parameter bit FSM_CHECKS = 1'b1
) (
  input logic          clk,
  input logic          reset_n,
  input cipher_state_t state,
  input logic          done,
  input logic          push,
  input logic          full,
  input logic          pop,
  input logic          empty
);

  no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
    push |-> !full)
    else $error("Queue push issued while full");

  no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
    pop |-> !empty)
    else $error("Queue pop issued while empty");

  // State and done checks where an FSM is attached
  if (FSM_CHECKS) begin : g_fsm
    logic [3:0] work_cycles;

    // Consecutive cycles spent in WORKING
    always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
        work_cycles <= '0;
      end else if (state == WORKING) begin
        work_cycles <= work_cycles + 1'b1;
      end else begin
        work_cycles <= '0;
      end
    end

    working_bound: assert property (@(posedge clk) disable iff (!reset_n)
      (state == WORKING) |-> (work_cycles < 4'(`CIPHER_ROUNDS)))
      else $error("FSM stayed in WORKING longer than %0d cycles", `CIPHER_ROUNDS);

    working_length: assert property (@(posedge clk) disable iff (!reset_n)
      (state == FINISHED && $past(state) == WORKING)
        |-> ($past(work_cycles) == 4'(`CIPHER_ROUNDS - 1)))
      else $error("FSM left WORKING after the wrong number of cycles");

    done_rise: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(done) |-> ($past(state) == FINISHED))
      else $error("Done flag rose outside the exit from FINISHED");
  end

endmodule

bind cipher_fsm cipher_asserts u_fsm_asserts (
  .clk     (clk),
  .reset_n (reset_n),
  .state   (state_q),
  .done    (done_q),
  .push    (snk.push),
  .full    (snk.full),
  .pop     (src.pop),
  .empty   (src.empty)
);

// Queue handshake checks only
bind stream_queue cipher_asserts #(.FSM_CHECKS(1'b0)) u_queue_asserts (
  .clk     (clk),
  .reset_n (reset_n),
  .state   (cipher_pkg::IDLE),
  .done    (1'b0),
  .push    (q.push),
  .full    (q.full),
  .pop     (q.pop),
  .empty   (q.empty)
);

`default_nettype wire

// ==== dv/cipher_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cipher_macros.svh"

module cipher_tb
  import cipher_pkg::*;
;

  localparam int CLK_PERIOD     = 10;
  localparam int DONE_POLLS     = 200;
  // Six tests of a few hundred cycles each, with ample margin
  localparam int TIMEOUT_CYCLES = 3000;

  logic                   clk;
  logic                   reset_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   irq;

  integer      seed;
  int          errors;
  int          checks;
  int          test_num;
  int          errors_at_start;
  int          cycles;
  logic [31:0] key;
  logic [3:0]  next_tag;
  logic [31:0] exp_ct_q[$];
  logic [3:0]  exp_tag_q[$];
  logic [31:0] obs_ct_q[$];
  logic [31:0] obs_tag_q[$];
  event        result_seen;

  cipher_top u_dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .irq_o     (irq)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a test never completed", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Expected ciphertext: key mix, rotate left by 3, add round number
  function automatic logic [31:0] cipher_ref(input logic [31:0] pt, input logic [31:0] k);
    logic [31:0] s;
    logic [31:0] rk;
    int          r;
    s = pt;
    for (r = 0; r < `CIPHER_ROUNDS; r++) begin
      rk = (r == 0) ? k : ((k << r) | (k >> (32 - r)));
      s  = s ^ rk;
      s  = {s[28:0], s[31:29]};
      s  = s + 32'(r);
    end
    return s;
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                           output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #1;
    err = pslverr;
    check_eq("pready_o in write access", 32'(pready), 32'd1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    check_eq("pready_o in read access", 32'(pready), 32'd1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Accepted plaintexts get the next tag and an expected result
  task automatic push_pt(input logic [31:0] pt, output logic err);
    apb_write(`REG_PT, pt, err);
    if (!err) begin
      exp_ct_q.push_back(cipher_ref(pt, key));
      exp_tag_q.push_back(next_tag);
      next_tag = next_tag + 1'b1;
    end
  endtask

  task automatic queue_blocks(input int n);
    logic err;
    for (int i = 0; i < n; i++) begin
      push_pt($random(seed), err);
      check_eq("pslverr_o on PT write", 32'(err), 32'd0);
    end
  endtask

  task automatic ctrl_write(input logic [31:0] value);
    logic err;
    apb_write(`REG_CTRL, value, err);
    check_eq("pslverr_o on CTRL write", 32'(err), 32'd0);
    if (value[1]) begin
      exp_ct_q.delete();
      exp_tag_q.delete();
    end
  endtask

  task automatic read_status(output logic [31:0] st);
    logic err;
    apb_read(`REG_STATUS, st, err);
    check_eq("pslverr_o on STATUS read", 32'(err), 32'd0);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    logic        err;
    int          polls;
    polls = 0;
    st    = '0;
    while (!st[0] && polls < DONE_POLLS) begin
      apb_read(`REG_STATUS, st, err);
      polls++;
    end
    checks++;
    assert (st[0]) else begin
      $display("Done flag never set after %0d STATUS reads", polls);
      errors++;
    end
  endtask

  // Tag first, since the RESULT read pops the head
  task automatic read_result();
    logic [31:0] tag;
    logic [31:0] ct;
    logic        err;
    apb_read(`REG_TAG, tag, err);
    check_eq("pslverr_o on TAG read", 32'(err), 32'd0);
    apb_read(`REG_RESULT, ct, err);
    check_eq("pslverr_o on RESULT read", 32'(err), 32'd0);
    obs_ct_q.push_back(ct);
    obs_tag_q.push_back(tag);
    -> result_seen;
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    test_num++;
    if (errors == errors_at_start) begin
      $display("Test %0d %s: pass", test_num, name);
    end else begin
      $display("Test %0d %s: fail, %0d errors", test_num, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // Compares each read-back result with the oldest expected one
  initial begin : compare_results
    logic [31:0] ct;
    logic [31:0] tag;
    forever begin
      @(result_seen);
      while (obs_ct_q.size() > 0) begin
        ct  = obs_ct_q.pop_front();
        tag = obs_tag_q.pop_front();
        checks++;
        assert (exp_ct_q.size() > 0) else begin
          $display("Result 0x%08h read back with no block outstanding", ct);
          errors++;
        end
        if (exp_ct_q.size() > 0) begin
          check_eq("prdata_o on RESULT", ct, exp_ct_q.pop_front());
          check_eq("prdata_o on TAG", tag, {28'b0, exp_tag_q.pop_front()});
        end
      end
    end
  end

  initial begin : run_tests
    logic [31:0] st;
    logic [31:0] data;
    logic        err;
    clk             = 1'b0;
    reset_n         = 1'b0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    seed            = 27;
    errors          = 0;
    checks          = 0;
    test_num        = 0;
    errors_at_start = 0;
    cycles          = 0;
    key             = '0;
    next_tag        = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    read_status(st);
    check_eq("STATUS after reset", st, 32'd0);
    check_eq("irq_o after reset", 32'(irq), 32'd0);
    finish_test("reset state");

    key = $random(seed);
    apb_write(`REG_KEY, key, err);
    queue_blocks(1);
    ctrl_write(32'h1);
    wait_done();
    check_eq("irq_o when done", 32'(irq), 32'd1);
    read_result();
    read_status(st);
    check_eq("STATUS busy bit", 32'(st[1]), 32'd0);
    finish_test("single block");

    queue_blocks(4);
    ctrl_write(32'h1);
    wait_done();
    repeat (4) read_result();
    finish_test("four queued blocks");

    key = $random(seed);
    apb_write(`REG_KEY, key, err);
    queue_blocks(4);
    ctrl_write(32'h1);
    wait_done();
    queue_blocks(2);
    ctrl_write(32'h1);
    // Sink full, so the FSM must stall in STARTING
    repeat (12) @(negedge clk);
    read_status(st);
    check_eq("STATUS busy bit under back-pressure", 32'(st[1]), 32'd1);
    check_eq("STATUS sink level under back-pressure", 32'(st[10:8]), 32'd4);
    check_eq("STATUS source level under back-pressure", 32'(st[6:4]), 32'd2);
    repeat (2) read_result();
    wait_done();
    repeat (4) read_result();
    finish_test("sink back-pressure");

    queue_blocks(4);
    push_pt($random(seed), err);
    check_eq("pslverr_o on PT write to full queue", 32'(err), 32'd1);
    apb_read(`REG_RESULT, data, err);
    check_eq("pslverr_o on RESULT read from empty queue", 32'(err), 32'd1);
    check_eq("prdata_o on empty RESULT read", data, 32'd0);
    apb_read(8'h20, data, err);
    check_eq("pslverr_o on unmapped read", 32'(err), 32'd1);
    read_status(st);
    check_eq("STATUS source level after errors", 32'(st[6:4]), 32'd4);
    check_eq("STATUS sink level after errors", 32'(st[10:8]), 32'd0);
    ctrl_write(32'h2);
    finish_test("error responses");

    queue_blocks(3);
    ctrl_write(32'h1);
    repeat (5) @(negedge clk);
    ctrl_write(32'h2);
    read_status(st);
    check_eq("STATUS after clear", st, 32'd0);
    check_eq("irq_o after clear", 32'(irq), 32'd0);
    finish_test("clear during run");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+source
source/cipher_pkg.sv
source/stream_queue_if.sv
source/stream_queue.sv
source/cipher_regfile.sv
source/cipher_fsm.sv
source/round_counter.sv
source/cipher_round_engine.sv
source/cipher_top.sv
dv/cipher_asserts.sv
dv/cipher_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := cipher_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Test run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
